/* design/pipeCtrl_macros.svh */
// Register file geometry for the pipeline control subsystem
// Sixteen registers, so a register number is four bits wide
// Register 0 reads as zero and is never a real hazard source

`ifndef PIPECTRL_MACROS_SVH
`define PIPECTRL_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Register number geometry
////////////////////////////////////////////////////////////////////////////
`define REG_W     4    // Bits in a register number
`define NUM_REGS  16   // Architectural register count

// Hard-wired zero register
`define REG_ZERO  0

`endif

/* design/pipeCtrlPkg.sv */
// Types shared by the pipeline control blocks
// Register numbers are plain vectors of REG_W bits
// The forwarding select uses a two-bit code with one spare value

`include "pipeCtrl_macros.svh"

package pipeCtrlPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register number
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [`REG_W-1:0] regId_t;   // Architectural register index

  ////////////////////////////////////////////////////////////////////////////
  // Execute operand source
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,   // Register file read value
    FWD_MEM  = 2'b01,   // EX/MEM result
    FWD_WB   = 2'b10    // MEM/WB result
  } fwdSel_t;

  // Code 2'b11 is never produced

endpackage

/* design/hazardDetect.sv */
// Decode-stage hazard rules, purely combinational
// Relies on IF/ID holding its fields while ifIdStall is high
// Stores spare the load-to-use stall on Rt thanks to MEM-MEM forwarding

`include "pipeCtrl_macros.svh"

module hazardDetect (
  input  pipeCtrlPkg::regId_t srcReg1,       // Rs in decode
  input  pipeCtrlPkg::regId_t srcReg2,       // Rt in decode
  input  logic                memWrite,      // Decode instruction is a store
  input  logic                branch,        // Any branch in decode
  input  logic                br,            // Register branch flavor
  input  logic                hlt,           // Halt in decode
  input  logic                updatePc,      // Redirect from branch resolution
  input  pipeCtrlPkg::regId_t idExDst,       // Rd in ID/EX
  input  logic                idExRegWrite,
  input  logic                idExMemEnable,
  input  logic                idExMemWrite,
  input  logic                idExZEn,       // ID/EX writes Z flag
  input  logic                idExNvEn,      // ID/EX writes N and V flags
  input  pipeCtrlPkg::regId_t exMemDst,      // Rd in EX/MEM
  input  logic                exMemRegWrite,
  output logic                pcStall,
  output logic                ifIdStall,
  output logic                idFlush,
  output logic                ifFlush
);

  import pipeCtrlPkg::*;

  localparam regId_t ZeroReg = regId_t'(`REG_ZERO);

  logic idExMemRead;    // Load sitting in execute
  logic flagPending;    // Flags still being produced in execute
  logic loadUse;
  logic bHazard;
  logic exToIdBr;       // ID/EX writes the BR target register
  logic memToIdBr;      // EX/MEM writes the BR target register
  logic brHazard;

  ////////////////////////////////////////////////////////////////////////////
  // Load-to-use
  ////////////////////////////////////////////////////////////////////////////
  assign idExMemRead = idExMemEnable & ~idExMemWrite;

  // Rt match is ignored for stores, the data arrives by MEM-MEM forwarding
  assign loadUse = idExMemRead & (idExDst != ZeroReg) &
                   ((idExDst == srcReg1) | ((idExDst == srcReg2) & ~memWrite));

  ////////////////////////////////////////////////////////////////////////////
  // Branches
  ////////////////////////////////////////////////////////////////////////////
  assign flagPending = idExZEn | idExNvEn;

  assign bHazard = branch & flagPending;   // Condition codes not ready yet

  // BR reads Rs in decode, so both later writers must drain first
  assign exToIdBr  = idExRegWrite & (idExDst != ZeroReg) & (idExDst == srcReg1);
  assign memToIdBr = exMemRegWrite & (exMemDst != ZeroReg) & (exMemDst == srcReg1);

  assign brHazard = branch & br & (flagPending | exToIdBr | memToIdBr);

  ////////////////////////////////////////////////////////////////////////////
  // Stall and flush outputs
  ////////////////////////////////////////////////////////////////////////////
  assign ifIdStall = hlt | loadUse | bHazard | brHazard;
  assign pcStall   = ifIdStall;                   // PC freezes with IF/ID

  // Halt holds without a bubble, hazards send a NOP down
  assign idFlush = loadUse | bHazard | brHazard;

  // Redirect kills the fetched word unless decode is held
  assign ifFlush = updatePc & ~ifIdStall;

endmodule

/* design/forwardSelect.sv */
// Execute operand forwarding and MEM-MEM store data forwarding
// EX/MEM wins over MEM/WB when both hold the same destination
// Writes to register 0 are never forwarded

`include "pipeCtrl_macros.svh"

module forwardSelect (
  input  pipeCtrlPkg::regId_t  idExSrc1,       // Rs in execute
  input  pipeCtrlPkg::regId_t  idExSrc2,       // Rt in execute
  input  pipeCtrlPkg::regId_t  exMemDst,
  input  logic                 exMemRegWrite,
  input  logic                 exMemMemWrite,  // Store in memory stage
  input  pipeCtrlPkg::regId_t  exMemSrc2,      // Store data register
  input  pipeCtrlPkg::regId_t  memWbDst,
  input  logic                 memWbRegWrite,
  output pipeCtrlPkg::fwdSel_t fwdA,
  output pipeCtrlPkg::fwdSel_t fwdB,
  output logic                 memFwd
);

  import pipeCtrlPkg::*;

  localparam regId_t ZeroReg = regId_t'(`REG_ZERO);

  logic exMemLive;   // EX/MEM result is a usable register value
  logic memWbLive;   // MEM/WB result is a usable register value

  assign exMemLive = exMemRegWrite & (exMemDst != ZeroReg);
  assign memWbLive = memWbRegWrite & (memWbDst != ZeroReg);

  // One rule for both operands with the youngest producer first
  function automatic fwdSel_t pickSrc(input regId_t src);
    fwdSel_t sel;
    sel = FWD_NONE;
    if (exMemLive && (exMemDst == src)) begin
      sel = FWD_MEM;
    end else if (memWbLive && (memWbDst == src)) begin
      sel = FWD_WB;
    end
    return sel;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Operand selects
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    fwdA = pickSrc(idExSrc1);
    fwdB = pickSrc(idExSrc2);
  end

  // Load result in writeback feeds the store data in memory stage
  assign memFwd = exMemMemWrite & memWbLive & (memWbDst == exMemSrc2);

endmodule

/* design/stageTracker.sv */
// Control-only copy of the ID/EX, EX/MEM and MEM/WB registers
// Never stalls because only PC and IF/ID freeze on a stall
// A flush or reset loads a bubble with every enable and register at zero

module stageTracker (
  input  logic                clk,
  input  logic                arstN,
  input  logic                idFlush,       // Bubble into ID/EX
  input  pipeCtrlPkg::regId_t srcReg1,       // Decode fields
  input  pipeCtrlPkg::regId_t srcReg2,
  input  pipeCtrlPkg::regId_t dstReg,
  input  logic                regWrite,
  input  logic                memEnable,
  input  logic                memWrite,
  input  logic                zEn,
  input  logic                nvEn,
  output pipeCtrlPkg::regId_t idExSrc1,
  output pipeCtrlPkg::regId_t idExSrc2,
  output pipeCtrlPkg::regId_t idExDst,
  output logic                idExRegWrite,
  output logic                idExMemEnable,
  output logic                idExMemWrite,
  output logic                idExZEn,
  output logic                idExNvEn,
  output pipeCtrlPkg::regId_t exMemDst,
  output logic                exMemRegWrite,
  output logic                exMemMemWrite,
  output pipeCtrlPkg::regId_t exMemSrc2,
  output pipeCtrlPkg::regId_t memWbDst,
  output logic                memWbRegWrite
);

  import pipeCtrlPkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idExSrc1      <= regId_t'('0);
      idExSrc2      <= regId_t'('0);
      idExDst       <= regId_t'('0);
      {idExRegWrite, idExMemEnable, idExMemWrite} <= 3'b000;
      {idExZEn, idExNvEn} <= 2'b00;
    end else if (idFlush) begin   // Sync bubble on a hazard
      idExSrc1      <= regId_t'('0);
      idExSrc2      <= regId_t'('0);
      idExDst       <= regId_t'('0);
      {idExRegWrite, idExMemEnable, idExMemWrite} <= 3'b000;
      {idExZEn, idExNvEn} <= 2'b00;
    end else begin
      idExSrc1      <= srcReg1;
      idExSrc2      <= srcReg2;
      idExDst       <= dstReg;
      idExRegWrite  <= regWrite;
      idExMemEnable <= memEnable;
      idExMemWrite  <= memWrite;
      idExZEn       <= zEn;
      idExNvEn      <= nvEn;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/MEM and MEM/WB shift every cycle
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMemDst      <= regId_t'('0);
      exMemRegWrite <= 1'b0;
      exMemMemWrite <= 1'b0;
      exMemSrc2     <= regId_t'('0);
      memWbDst      <= regId_t'('0);
      memWbRegWrite <= 1'b0;
    end else begin
      exMemDst      <= idExDst;
      exMemRegWrite <= idExRegWrite;
      exMemMemWrite <= idExMemEnable & idExMemWrite;   // Real store only
      exMemSrc2     <= idExSrc2;                       // Store data reg
      memWbDst      <= exMemDst;
      memWbRegWrite <= exMemRegWrite;
    end
  end

endmodule

/* design/pipeCtrlTop.sv */
// Pipeline control top, wiring only
// Stalls and flushes are combinational from the decode inputs
// idFlush loops back into the tracker to bubble ID/EX on the next edge

module pipeCtrlTop (
  input  logic                 clk,
  input  logic                 arstN,
  input  pipeCtrlPkg::regId_t  srcReg1,
  input  pipeCtrlPkg::regId_t  srcReg2,
  input  pipeCtrlPkg::regId_t  dstReg,
  input  logic                 regWrite,
  input  logic                 memEnable,
  input  logic                 memWrite,
  input  logic                 zEn,
  input  logic                 nvEn,
  input  logic                 branch,
  input  logic                 br,
  input  logic                 hlt,
  input  logic                 updatePc,
  output logic                 pcStall,
  output logic                 ifIdStall,
  output logic                 idFlush,
  output logic                 ifFlush,
  output pipeCtrlPkg::fwdSel_t fwdA,
  output pipeCtrlPkg::fwdSel_t fwdB,
  output logic                 memFwd
);

  import pipeCtrlPkg::*;

  regId_t idExSrc1, idExSrc2, idExDst;     // Execute stage
  logic   idExRegWrite, idExMemEnable, idExMemWrite, idExZEn, idExNvEn;
  regId_t exMemDst, exMemSrc2;             // Memory stage
  logic   exMemRegWrite, exMemMemWrite;
  regId_t memWbDst;                        // Writeback stage
  logic   memWbRegWrite;

  stageTracker stageTracker_inst (
    .clk, .arstN, .idFlush,
    .srcReg1, .srcReg2, .dstReg, .regWrite, .memEnable, .memWrite, .zEn, .nvEn,
    .idExSrc1, .idExSrc2, .idExDst, .idExRegWrite, .idExMemEnable, .idExMemWrite,
    .idExZEn, .idExNvEn, .exMemDst, .exMemRegWrite, .exMemMemWrite, .exMemSrc2,
    .memWbDst, .memWbRegWrite
  );

  hazardDetect hazardDetect_inst (
    .srcReg1, .srcReg2, .memWrite, .branch, .br, .hlt, .updatePc,
    .idExDst, .idExRegWrite, .idExMemEnable, .idExMemWrite, .idExZEn, .idExNvEn,
    .exMemDst, .exMemRegWrite,
    .pcStall, .ifIdStall, .idFlush, .ifFlush
  );

  forwardSelect forwardSelect_inst (
    .idExSrc1, .idExSrc2, .exMemDst, .exMemRegWrite, .exMemMemWrite, .exMemSrc2,
    .memWbDst, .memWbRegWrite, .fwdA, .fwdB, .memFwd
  );

endmodule

/* bench/pipeCtrl_assertions.sv */
// Stall and flush invariants, bound into the pipeline control top
// Sampled on the rising clock and idle while arstN is low
// The bubble check relies on idFlush reaching the tracker on the same edge

module pipeCtrlAssertions (
  input logic clk,
  input logic arstN,
  input logic pcStall,
  input logic ifIdStall,
  input logic idFlush,
  input logic ifFlush,
  input logic idExRegWrite,     // Tracker ID/EX enables
  input logic idExMemEnable,
  input logic idExMemWrite,
  input logic idExZEn,
  input logic idExNvEn
);

  logic idExAnyEn;   // Any enable still live in execute

  assign idExAnyEn = idExRegWrite | idExMemEnable | idExMemWrite | idExZEn | idExNvEn;

  stallPair: assert property (@(posedge clk) disable iff (!arstN) pcStall == ifIdStall)
    else $error("pcStall and ifIdStall differ");

  // A redirect never kills a word that decode is holding
  flushVsStall: assert property (@(posedge clk) disable iff (!arstN) !(ifFlush && ifIdStall))
    else $error("ifFlush raised while IF/ID is stalled");

  bubbleNeedsStall: assert property (@(posedge clk) disable iff (!arstN) idFlush |-> ifIdStall)
    else $error("idFlush raised without a stall");

  bubbleLoaded: assert property (@(posedge clk) disable iff (!arstN) idFlush |=> !idExAnyEn)
    else $error("ID/EX enables live in the cycle after idFlush");

endmodule

bind pipeCtrlTop pipeCtrlAssertions pipeCtrlAssertions_inst (
  .clk, .arstN, .pcStall, .ifIdStall, .idFlush, .ifFlush,
  .idExRegWrite, .idExMemEnable, .idExMemWrite, .idExZEn, .idExNvEn
);

/* bench/pipeCtrlTb.sv */
// Table-driven testbench for the pipeline control top
// Inputs change on the falling edge and outputs are checked before the rising edge
// Expected values are worked out by hand from the hazard and forwarding rules
// A held instruction repeats its row once per stall cycle

module pipeCtrlTb;

  import pipeCtrlPkg::*;

  localparam int HalfPeriod   = 50;
  localparam int ResetCycles  = 5;
  localparam int ResetTimeout = 20;    // Cycles allowed for reset release
  localparam int RunLimit     = 400;   // Watchdog in clock cycles
  localparam int SettleDelay  = 10;    // Sample point after the falling edge

  // Control codes {regWrite | memEnable memWrite zEn nvEn | branch br hlt updatePc}
  localparam logic [8:0] CtlNop   = 9'b0_0000_0000;
  localparam logic [8:0] CtlLoad  = 9'b1_1000_0000;
  localparam logic [8:0] CtlStore = 9'b0_1100_0000;
  localparam logic [8:0] CtlAlu   = 9'b1_0000_0000;
  localparam logic [8:0] CtlAluF  = 9'b1_0011_0000;   // ALU that sets flags
  localparam logic [8:0] CtlB     = 9'b0_0000_1000;
  localparam logic [8:0] CtlBr    = 9'b0_0000_1100;
  localparam logic [8:0] CtlHlt   = 9'b0_0000_0010;
  localparam logic [8:0] CtlPc    = 9'b0_0000_0001;   // Redirect from resolution

  typedef struct packed {
    regId_t src1;
    regId_t src2;
    regId_t dst;
    logic   regWrite, memEnable, memWrite, zEn, nvEn;
    logic   branch, br, hlt, updatePc;
  } decode_t;

  typedef struct packed {
    decode_t    dec;
    logic [3:0] haz;      // {pcStall, ifIdStall, idFlush, ifFlush}
    fwdSel_t    fwdA;
    fwdSel_t    fwdB;
    logic       memFwd;
  } row_t;

  logic    clk = 1'b0;
  logic    arstN;
  regId_t  srcReg1, srcReg2, dstReg;
  logic    regWrite, memEnable, memWrite, zEn, nvEn, branch, br, hlt, updatePc;
  logic    pcStall, ifIdStall, idFlush, ifFlush, memFwd;
  fwdSel_t fwdA, fwdB;

  string testNames[$];
  row_t  rows[$];
  int    errCount = 0;

  pipeCtrlTop pipeCtrlTop_inst (
    .clk, .arstN, .srcReg1, .srcReg2, .dstReg, .regWrite, .memEnable, .memWrite,
    .zEn, .nvEn, .branch, .br, .hlt, .updatePc,
    .pcStall, .ifIdStall, .idFlush, .ifFlush, .fwdA, .fwdB, .memFwd
  );

  always #(HalfPeriod) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Table helpers and compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic addRow(input string name, input int s1, input int s2, input int dst,
                        input logic [8:0] ctrl, input logic [3:0] haz,
                        input fwdSel_t a, input fwdSel_t b, input logic mf);
    row_t r;
    r.dec    = {regId_t'(s1), regId_t'(s2), regId_t'(dst), ctrl};
    r.haz    = haz;
    r.fwdA   = a;
    r.fwdB   = b;
    r.memFwd = mf;
    testNames.push_back(name);
    rows.push_back(r);
  endtask

  task automatic applyDecode(input decode_t d);
    srcReg1   = d.src1;
    srcReg2   = d.src2;
    dstReg    = d.dst;
    {regWrite, memEnable, memWrite, zEn, nvEn} = {d.regWrite, d.memEnable, d.memWrite,
                                                  d.zEn, d.nvEn};
    {branch, br, hlt, updatePc} = {d.branch, d.br, d.hlt, d.updatePc};
  endtask

  task automatic checkBit(input string testName, input string sigName,
                          input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      errCount++;
      $display("[ERROR] %s %s expected %b actual %b", testName, sigName, expVal, actVal);
    end
  endtask

  task automatic checkFwd(input string testName, input string sigName,
                          input fwdSel_t expVal, input fwdSel_t actVal);
    if (actVal !== expVal) begin
      errCount++;
      $display("[ERROR] %s %s expected %s actual %s (%0d)", testName, sigName,
               expVal.name(), actVal.name(), actVal);
    end
  endtask

  task automatic checkRow(input string testName, input row_t r);
    checkBit(testName, "pcStall",   r.haz[3], pcStall);
    checkBit(testName, "ifIdStall", r.haz[2], ifIdStall);
    checkBit(testName, "idFlush",   r.haz[1], idFlush);
    checkBit(testName, "ifFlush",   r.haz[0], ifFlush);
    checkFwd(testName, "fwdA", r.fwdA, fwdA);
    checkFwd(testName, "fwdB", r.fwdB, fwdB);
    checkBit(testName, "memFwd", r.memFwd, memFwd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////
  task automatic buildTable();
    // name, src1, src2, dst, control, stall/flush, fwdA, fwdB, memFwd
    addRow("reset_idle_0",    0, 0, 0, CtlNop,  4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("reset_idle_1",    0, 0, 0, CtlNop,  4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("ld_r3",           1, 0, 3, CtlLoad, 4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("use_r3_stall",    3, 2, 4, CtlAlu,  4'b1110, FWD_NONE, FWD_NONE, 1'b0);
    addRow("use_r3_go",       3, 2, 4, CtlAlu,  4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("ld_r6_fwd_wb",    1, 0, 6, CtlLoad, 4'b0000, FWD_WB,   FWD_NONE, 1'b0);
    addRow("st_r6_nostall",   5, 6, 0, CtlStore, 4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("st_r6_ex",        0, 0, 0, CtlNop,  4'b0000, FWD_NONE, FWD_MEM,  1'b0);
    addRow("st_r6_memfwd",    0, 0, 0, CtlNop,  4'b0000, FWD_NONE, FWD_NONE, 1'b1);
    addRow("drain_a",         0, 0, 0, CtlNop,  4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("ld_r0",           1, 0, 0, CtlLoad, 4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("use_r0",          0, 0, 7, CtlAlu,  4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("ld_r8",           1, 0, 8, CtlLoad, 4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("nomatch_r8",      2, 5, 9, CtlAlu,  4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("drain_c",         0, 0, 0, CtlNop,  4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    // Branch hazards
    addRow("alu_flags",       2, 5, 10, CtlAluF, 4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("b_stall",         0, 0, 0, CtlB,    4'b1110, FWD_NONE, FWD_NONE, 1'b0);
    addRow("b_go",            0, 0, 0, CtlB,    4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("alu_r11",         2, 5, 11, CtlAlu, 4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("br_stall_ex",     11, 0, 0, CtlBr,  4'b1110, FWD_NONE, FWD_NONE, 1'b0);
    addRow("br_stall_mem",    11, 0, 0, CtlBr,  4'b1110, FWD_NONE, FWD_NONE, 1'b0);
    addRow("br_go",           11, 0, 0, CtlBr,  4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    // Halt and redirect
    addRow("redirect",        0, 0, 0, CtlPc,   4'b0001, FWD_NONE, FWD_NONE, 1'b0);
    addRow("halt",            0, 0, 0, CtlHlt,  4'b1100, FWD_NONE, FWD_NONE, 1'b0);
    addRow("halt_redirect",   0, 0, 0, CtlHlt | CtlPc, 4'b1100, FWD_NONE, FWD_NONE, 1'b0);
    addRow("ld_r12",          1, 0, 12, CtlLoad, 4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("use_r12_masked",  12, 2, 13, CtlAlu | CtlPc, 4'b1110, FWD_NONE, FWD_NONE, 1'b0);
    addRow("use_r12_go",      12, 2, 13, CtlAlu, 4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    // Forwarding priority with r14 written twice in a row
    addRow("alu_r14_a",       2, 5, 14, CtlAlu, 4'b0000, FWD_WB,   FWD_NONE, 1'b0);
    addRow("alu_r14_b",       2, 5, 14, CtlAlu, 4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("use_r14",         14, 14, 15, CtlAlu, 4'b0000, FWD_NONE, FWD_NONE, 1'b0);
    addRow("fwd_prio",        0, 0, 0, CtlNop,  4'b0000, FWD_MEM,  FWD_MEM,  1'b0);
    addRow("drain_f",         0, 0, 0, CtlNop,  4'b0000, FWD_NONE, FWD_NONE, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reset, watchdog and main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    arstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;   // Release on the falling edge
  end

  initial begin
    repeat (RunLimit) @(posedge clk);
    $display("Run did not finish within %0d clock cycles", RunLimit);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    int waitCycles;
    applyDecode('0);   // Decode fields idle through reset
    buildTable();
    waitCycles = 0;
    while (arstN !== 1'b1 && waitCycles < ResetTimeout) begin
      @(posedge clk);
      waitCycles++;
    end
    if (arstN !== 1'b1) begin
      $display("Reset was not released after %0d cycles", ResetTimeout);
      $display("TB FAILED");
      $finish;
    end else begin
      for (int i = 0; i < rows.size(); i++) begin
        @(negedge clk);
        applyDecode(rows[i].dec);
        #(SettleDelay);               // Combinational outputs settled
        checkRow(testNames[i], rows[i]);
      end
      $display("Checks done over %0d rows, %0d errors", rows.size(), errCount);
      if (errCount == 0) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
      $finish;
    end
  end

endmodule

/* pipeCtrl.f */
+incdir+design
design/pipeCtrlPkg.sv
design/hazardDetect.sv
design/forwardSelect.sv
design/stageTracker.sv
design/pipeCtrlTop.sv
bench/pipeCtrl_assertions.sv
bench/pipeCtrlTb.sv

/* Makefile */
# Verilator build and run for the pipeline control subsystem

TOP := pipeCtrlTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f pipeCtrl.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
